// ==== dvi_sync_pkg.sv ====
/*
 * shared widths, chip codes and native raster timing for the DVI doubler
 * window limits are native values, frame sizes are already doubled
 */
`default_nettype none

package dvi_sync_pkg;

    typedef logic [10:0] hcount_t;  // output x, doubled
    typedef logic [9:0]  vcount_t;  // output y, doubled
    typedef logic [9:0]  rx_t;      // native raster x
    typedef logic [8:0]  ry_t;      // native raster y
    typedef logic [3:0]  color_t;   // palette index
    typedef logic [1:0]  chip_t;    // bit 0 set means PAL

    // chip codes
    localparam chip_t CHIP_6567R8   = 2'd0;
    localparam chip_t CHIP_6569R3   = 2'd1;
    localparam chip_t CHIP_6567R56A = 2'd2;
    localparam chip_t CHIP_6569R1   = 2'd3;

    localparam int LINE_ADDR_W = 11;  // covers the 520 pixel native line

    // ------------------------------------------------------------------
    // PAL 6569, vertical blank wraps through 0 so va_sta/va_end are swapped
    localparam logic [9:0] PAL_HA_END = 10'd0;
    localparam logic [9:0] PAL_HS_STA = 10'd10;   // front porch 10
    localparam logic [9:0] PAL_HS_END = 10'd70;   // sync 60
    localparam logic [9:0] PAL_HA_STA = 10'd90;   // back porch 20
    localparam logic [9:0] PAL_VA_END = 10'd20;   // really the first visible line
    localparam logic [9:0] PAL_VS_STA = 10'd284;
    localparam logic [9:0] PAL_VS_END = 10'd289;
    localparam logic [9:0] PAL_VA_STA = 10'd291;  // really the end of the visible area
    localparam hcount_t    PAL_MAX_W    = 11'd944;
    localparam vcount_t    PAL_MAX_H    = 10'd623;
    localparam hcount_t    PAL_X_OFFSET = 11'd30;

    // ------------------------------------------------------------------
    // NTSC 6567R8, 520 x 263
    localparam logic [9:0] NTSC_R8_HA_END = 10'd0;
    localparam logic [9:0] NTSC_R8_HS_STA = 10'd5;
    localparam logic [9:0] NTSC_R8_HS_END = 10'd35;
    localparam logic [9:0] NTSC_R8_HA_STA = 10'd40;
    localparam logic [9:0] NTSC_R8_VA_END = 10'd11;
    localparam logic [9:0] NTSC_R8_VS_STA = 10'd19;
    localparam logic [9:0] NTSC_R8_VS_END = 10'd23;
    localparam logic [9:0] NTSC_R8_VA_STA = 10'd27;
    localparam hcount_t    NTSC_R8_MAX_W    = 11'd844;
    localparam vcount_t    NTSC_R8_MAX_H    = 10'd525;
    localparam hcount_t    NTSC_R8_X_OFFSET = 11'd142;

    // ------------------------------------------------------------------
    // NTSC 6567R56A, 512 x 262, same windows as R8
    localparam logic [9:0] NTSC_R56A_HA_END = 10'd0;
    localparam logic [9:0] NTSC_R56A_HS_STA = 10'd5;
    localparam logic [9:0] NTSC_R56A_HS_END = 10'd35;
    localparam logic [9:0] NTSC_R56A_HA_STA = 10'd40;
    localparam logic [9:0] NTSC_R56A_VA_END = 10'd11;
    localparam logic [9:0] NTSC_R56A_VS_STA = 10'd19;
    localparam logic [9:0] NTSC_R56A_VS_END = 10'd23;
    localparam logic [9:0] NTSC_R56A_VA_STA = 10'd27;
    localparam hcount_t    NTSC_R56A_MAX_W    = 11'd831;
    localparam vcount_t    NTSC_R56A_MAX_H    = 10'd523;
    localparam hcount_t    NTSC_R56A_X_OFFSET = 11'd146;

endpackage

`default_nettype wire

// ==== line_buf_ram.sv ====
/*
 * single port line RAM, read data registered one cycle after re
 * no reset on the array or the read register
 */
`timescale 1ns/1ps
`default_nettype none

module line_buf_ram (
    input  wire                                clk_dvi,
    input  wire logic                          we,
    input  wire logic                          re,
    input  wire logic [dvi_sync_pkg::LINE_ADDR_W-1:0] addr,
    input  wire dvi_sync_pkg::color_t          din,
    output dvi_sync_pkg::color_t               dout
);
    import dvi_sync_pkg::*;

    (* ram_style = "block" *) color_t mem [2**LINE_ADDR_W];  // one raster line

    always_ff @(posedge clk_dvi) begin
        if (we) begin
            mem[addr] <= din;
        end
        if (re) begin
            dout <= mem[addr];  // hold last word when not reading
        end
    end

endmodule

`default_nettype wire

// ==== line_double_buffer.sv ====
/*
 * ping-pong line store, one RAM fills from the pixel stream while the other drains
 * output lags the addressing h_count by two cycles
 */
`timescale 1ns/1ps
`default_nettype none

module line_double_buffer (
    input  wire                          clk_dvi,
    input  wire                          rst,
    input  wire                          pixel_we,
    input  wire dvi_sync_pkg::rx_t       raster_x,
    input  wire dvi_sync_pkg::color_t    pixel_color,
    input  wire dvi_sync_pkg::hcount_t   h_count,
    input  wire dvi_sync_pkg::hcount_t   x_offset,
    output dvi_sync_pkg::color_t         pixel_color_out
);
    import dvi_sync_pkg::*;

    logic                   sel;       // ram currently being filled
    logic                   wr_sel;    // fill ram for this cycle, flips early at line start
    logic                   rd_sel_d;  // drained ram, aligned with ram read data
    logic                   line_start;
    hcount_t                rd_sum;
    logic [LINE_ADDR_W-1:0] rd_addr;
    logic [LINE_ADDR_W-1:0] wr_addr;
    color_t                 dout [2];

    assign line_start = pixel_we && (raster_x == '0);
    assign wr_sel     = line_start ? ~sel : sel;  // first pixel lands in the new buffer
    assign rd_sum     = h_count + x_offset;
    assign rd_addr    = rd_sum >> 1;               // each native pixel shown twice
    assign wr_addr    = LINE_ADDR_W'(raster_x);

    // ------------------------------------------------------------------
    // two rams, each either written or read in a given cycle
    for (genvar i = 0; i < 2; i++) begin : g_ram
        line_buf_ram ram_i (
            .clk_dvi (clk_dvi),
            .we      (pixel_we && (wr_sel == 1'(i))),
            .re      (wr_sel != 1'(i)),
            .addr    ((wr_sel == 1'(i)) ? wr_addr : rd_addr),
            .din     (pixel_color),
            .dout    (dout[i])
        );
    end

    always_ff @(posedge clk_dvi) begin
        if (rst) begin
            sel             <= 1'b0;
            rd_sel_d        <= 1'b0;
            pixel_color_out <= '0;
        end else begin
            sel             <= wr_sel;
            rd_sel_d        <= ~wr_sel;         // ram that was read this cycle
            pixel_color_out <= dout[rd_sel_d];  // second stage, output register
        end
    end

endmodule

`default_nettype wire

// ==== raster_timing.sv ====
/*
 * chip table is sampled during reset and again at each frame start
 * all window limits come out doubled in both directions
 */
`timescale 1ns/1ps
`default_nettype none

module raster_timing (
    input  wire                          clk_dvi,
    input  wire                          rst,
    input  wire dvi_sync_pkg::chip_t     chip,
    input  wire                          frame_start,
    output logic                         pal,
    output dvi_sync_pkg::hcount_t        max_w,
    output dvi_sync_pkg::vcount_t        max_h,
    output dvi_sync_pkg::hcount_t        x_offset,
    output dvi_sync_pkg::hcount_t        ha_end,
    output dvi_sync_pkg::hcount_t        hs_sta,
    output dvi_sync_pkg::hcount_t        hs_end,
    output dvi_sync_pkg::hcount_t        ha_sta,
    output dvi_sync_pkg::vcount_t        va_end,
    output dvi_sync_pkg::vcount_t        vs_sta,
    output dvi_sync_pkg::vcount_t        vs_end,
    output dvi_sync_pkg::vcount_t        va_sta
);
    import dvi_sync_pkg::*;

    function automatic hcount_t dbl_h(input logic [9:0] n);
        return {n, 1'b0};  // 2x horizontal
    endfunction

    function automatic vcount_t dbl_v(input logic [9:0] n);
        return {n[8:0], 1'b0};  // 2y, native lines stay below 512
    endfunction

    always_ff @(posedge clk_dvi) begin
        if (rst || frame_start) begin
            pal <= chip[0];
            case (chip)
                CHIP_6569R3, CHIP_6569R1: begin
                    ha_end   <= dbl_h(PAL_HA_END);
                    hs_sta   <= dbl_h(PAL_HS_STA);
                    hs_end   <= dbl_h(PAL_HS_END);
                    ha_sta   <= dbl_h(PAL_HA_STA);
                    va_end   <= dbl_v(PAL_VA_END);  // inverted range, see sync_encoder
                    vs_sta   <= dbl_v(PAL_VS_STA);
                    vs_end   <= dbl_v(PAL_VS_END);
                    va_sta   <= dbl_v(PAL_VA_STA);
                    max_w    <= PAL_MAX_W;
                    max_h    <= PAL_MAX_H;
                    x_offset <= PAL_X_OFFSET;
                end
                CHIP_6567R8: begin
                    ha_end   <= dbl_h(NTSC_R8_HA_END);
                    hs_sta   <= dbl_h(NTSC_R8_HS_STA);
                    hs_end   <= dbl_h(NTSC_R8_HS_END);
                    ha_sta   <= dbl_h(NTSC_R8_HA_STA);
                    va_end   <= dbl_v(NTSC_R8_VA_END);
                    vs_sta   <= dbl_v(NTSC_R8_VS_STA);
                    vs_end   <= dbl_v(NTSC_R8_VS_END);
                    va_sta   <= dbl_v(NTSC_R8_VA_STA);
                    max_w    <= NTSC_R8_MAX_W;
                    max_h    <= NTSC_R8_MAX_H;
                    x_offset <= NTSC_R8_X_OFFSET;
                end
                CHIP_6567R56A: begin
                    ha_end   <= dbl_h(NTSC_R56A_HA_END);
                    hs_sta   <= dbl_h(NTSC_R56A_HS_STA);
                    hs_end   <= dbl_h(NTSC_R56A_HS_END);
                    ha_sta   <= dbl_h(NTSC_R56A_HA_STA);
                    va_end   <= dbl_v(NTSC_R56A_VA_END);
                    vs_sta   <= dbl_v(NTSC_R56A_VS_STA);
                    vs_end   <= dbl_v(NTSC_R56A_VS_END);
                    va_sta   <= dbl_v(NTSC_R56A_VA_STA);
                    max_w    <= NTSC_R56A_MAX_W;
                    max_h    <= NTSC_R56A_MAX_H;
                    x_offset <= NTSC_R56A_X_OFFSET;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== scan_counter.sv ====
/*
 * free running doubled raster counters, line is max_w+1 clocks
 * frame_start forces the next h wrap to begin line 0
 */
`timescale 1ns/1ps
`default_nettype none

module scan_counter (
    input  wire                          clk_dvi,
    input  wire                          rst,
    input  wire                          frame_start,
    input  wire dvi_sync_pkg::hcount_t   max_w,
    input  wire dvi_sync_pkg::vcount_t   max_h,
    input  wire                          vblank,
    output dvi_sync_pkg::hcount_t        h_count,
    output dvi_sync_pkg::vcount_t        v_count,
    output logic                         half_bright
);
    import dvi_sync_pkg::*;

    logic h_wrap;

    assign h_wrap = (h_count >= max_w);  // >= also catches a shrink after chip change

    always_ff @(posedge clk_dvi) begin
        if (rst) begin
            h_count     <= '0;
            v_count     <= '0;
            half_bright <= 1'b0;
        end else begin
            if (h_wrap) begin
                h_count <= '0;
                if (v_count >= max_h) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 1'b1;
                end
                // alternate lines dimmed while vertically blanked
                if (vblank) begin
                    half_bright <= ~half_bright;
                end else begin
                    half_bright <= 1'b0;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end

            // resync to the source frame, wins over the v step above
            if (frame_start) begin
                v_count <= max_h;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sync_encoder.sv ====
/*
 * purely combinational, no output registers
 * with csync enabled vsync is held at 0 and hsync carries both pulses
 */
`timescale 1ns/1ps
`default_nettype none

module sync_encoder (
    input  wire dvi_sync_pkg::hcount_t   h_count,
    input  wire dvi_sync_pkg::vcount_t   v_count,
    input  wire dvi_sync_pkg::hcount_t   ha_end,
    input  wire dvi_sync_pkg::hcount_t   hs_sta,
    input  wire dvi_sync_pkg::hcount_t   hs_end,
    input  wire dvi_sync_pkg::hcount_t   ha_sta,
    input  wire dvi_sync_pkg::vcount_t   va_end,
    input  wire dvi_sync_pkg::vcount_t   vs_sta,
    input  wire dvi_sync_pkg::vcount_t   vs_end,
    input  wire dvi_sync_pkg::vcount_t   va_sta,
    input  wire                          pal,
    input  wire                          hpolarity,
    input  wire                          vpolarity,
    input  wire                          enable_csync,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         active,
    output logic                         vblank
);
    logic hsync_ah;  // active high internals
    logic vsync_ah;
    logic csync_ah;
    logic hblank;
    logic vrange;    // lines va_end..va_sta, meaning flips for PAL

    assign hsync_ah = (h_count >= hs_sta) && (h_count <= hs_end);

    // vsync edges line up with hsync so first and last lines are not cut short
    assign vsync_ah = ((v_count == vs_sta && h_count >= hs_sta) || v_count > vs_sta) &&
                      ((v_count == vs_end && h_count < hs_end) || v_count < vs_end);
    assign csync_ah = hsync_ah || vsync_ah;

    // ------------------------------------------------------------------
    // blanking windows
    assign hblank = (h_count >= ha_end) && (h_count <= ha_sta);
    assign vrange = ((v_count == va_end && h_count >= ha_end) || v_count > va_end) &&
                    ((v_count == va_sta && h_count < ha_sta) || v_count < va_sta);
    assign vblank = pal ? ~vrange : vrange;  // PAL blank crosses line 0
    assign active = ~(hblank || vblank);

    // polarity low means active low sync
    assign hsync = enable_csync ? (hpolarity ? csync_ah : ~csync_ah)
                                : (hpolarity ? hsync_ah : ~hsync_ah);
    assign vsync = enable_csync ? 1'b0 : (vpolarity ? vsync_ah : ~vsync_ah);

endmodule

`default_nettype wire

// ==== dvi_sync_top.sv ====
/*
 * single clock domain, pixel stream arrives on clk_dvi with a write strobe
 * no back-pressure, every strobed pixel is stored
 */
`timescale 1ns/1ps
`default_nettype none

module dvi_sync_top (
    input  wire                          clk_dvi,
    input  wire                          rst,
    input  wire dvi_sync_pkg::chip_t     chip,
    input  wire                          hpolarity,
    input  wire                          vpolarity,
    input  wire                          enable_csync,
    input  wire                          pixel_we,
    input  wire dvi_sync_pkg::rx_t       raster_x,
    input  wire dvi_sync_pkg::ry_t       raster_y,
    input  wire dvi_sync_pkg::color_t    pixel_color,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         active,
    output dvi_sync_pkg::color_t         pixel_color_out,
    output logic                         half_bright
);
    import dvi_sync_pkg::*;

    logic    frame_start;
    logic    pal;
    logic    vblank;
    hcount_t max_w, x_offset, h_count;
    hcount_t ha_end, hs_sta, hs_end, ha_sta;
    vcount_t max_h, v_count;
    vcount_t va_end, vs_sta, vs_end, va_sta;

    assign frame_start = pixel_we && (raster_x == '0) && (raster_y == '0);  // pixel 0,0

    raster_timing timing_i (
        .clk_dvi (clk_dvi), .rst (rst), .chip (chip), .frame_start (frame_start),
        .pal (pal), .max_w (max_w), .max_h (max_h), .x_offset (x_offset),
        .ha_end (ha_end), .hs_sta (hs_sta), .hs_end (hs_end), .ha_sta (ha_sta),
        .va_end (va_end), .vs_sta (vs_sta), .vs_end (vs_end), .va_sta (va_sta)
    );

    scan_counter counter_i (
        .clk_dvi (clk_dvi), .rst (rst), .frame_start (frame_start),
        .max_w (max_w), .max_h (max_h), .vblank (vblank),
        .h_count (h_count), .v_count (v_count), .half_bright (half_bright)
    );

    sync_encoder encoder_i (
        .h_count (h_count), .v_count (v_count),
        .ha_end (ha_end), .hs_sta (hs_sta), .hs_end (hs_end), .ha_sta (ha_sta),
        .va_end (va_end), .vs_sta (vs_sta), .vs_end (vs_end), .va_sta (va_sta),
        .pal (pal), .hpolarity (hpolarity), .vpolarity (vpolarity),
        .enable_csync (enable_csync),
        .hsync (hsync), .vsync (vsync), .active (active), .vblank (vblank)
    );

    line_double_buffer linebuf_i (
        .clk_dvi (clk_dvi), .rst (rst), .pixel_we (pixel_we), .raster_x (raster_x),
        .pixel_color (pixel_color), .h_count (h_count), .x_offset (x_offset),
        .pixel_color_out (pixel_color_out)
    );

endmodule

`default_nettype wire

// ==== tb_dvi_sync.sv ====
/*
 * self-checking testbench, DUT outputs are sampled on the falling clock edge
 * each table row resets the DUT with a new chip and runs for most of one frame
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dvi_sync;
    import dvi_sync_pkg::*;

    localparam int TMO      = 1000000;  // cycles, longer than a PAL frame
    localparam int LINE_PIX = 520;      // native pixels written per line
    localparam int NROWS    = 4;

    typedef struct packed {
        chip_t   chip;
        logic    hpol, vpol, csync, pal;
        hcount_t max_w, xoff;
        vcount_t max_h;
        vcount_t vb_lo, vb_hi;  // doubled va_end, va_sta
        hcount_t line_len;      // cycles between hsync leading edges
        hcount_t hs_w;
        hcount_t act_w;         // active cycles on a visible line
        vcount_t vs_lines;      // vsync length as whole lines
        hcount_t vs_rem;        // plus this many cycles
    } row_t;

    logic        clk_dvi, rst;
    chip_t       chip;
    logic        hpolarity, vpolarity, enable_csync;
    logic        pixel_we;
    rx_t         raster_x;
    ry_t         raster_y;
    color_t      pixel_color;
    logic        hsync, vsync, active, half_bright;
    color_t      pixel_color_out;

    row_t        rows [NROWS];
    row_t        cur;                  // row under test
    color_t      ref_line [LINE_PIX];  // copy of the line in the read buffer
    logic [31:0] lfsr;
    int          errors, timeouts;
    logic        hung;                 // first timeout makes later waits fall through
    logic        chk_col;
    hcount_t     mh, mh_d1, mh_d2;     // counter model, plus two cycles of h history
    vcount_t     mv;
    logic        mhb;

    dvi_sync_top dut_i (
        .clk_dvi (clk_dvi), .rst (rst), .chip (chip), .hpolarity (hpolarity),
        .vpolarity (vpolarity), .enable_csync (enable_csync), .pixel_we (pixel_we),
        .raster_x (raster_x), .raster_y (raster_y), .pixel_color (pixel_color),
        .hsync (hsync), .vsync (vsync), .active (active),
        .pixel_color_out (pixel_color_out), .half_bright (half_bright)
    );

    initial begin
        clk_dvi = 1'b0;
        forever #4 clk_dvi = ~clk_dvi;  // 125 MHz
    end

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic next_color(output color_t c);
        for (int b = 0; b < 4; b++) begin
            c[b] = lfsr[0];  // one step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic log_error(input string name, input string exp_s, input string act_s);
        if (!hung) begin
            errors++;
            $display("Error %s: expected %s, actual %s", name, exp_s, act_s);
        end
    endtask

    task automatic timed_out(input string what);
        if (!hung) $display("timed out waiting for %s", what);
        hung = 1'b1;
        timeouts++;
    endtask

    task automatic check_h(input string name, input hcount_t exp, input hcount_t act);
        if (act !== exp) log_error(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic check_v(input string name, input vcount_t exp, input vcount_t act);
        if (act !== exp) log_error(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic check_color(input string name, input color_t exp, input color_t act);
        if (act !== exp) log_error(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) log_error(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    // blank test for a whole line, taken at the line's last pixel
    function automatic logic in_vblank(input vcount_t v);
        return ((v >= cur.vb_lo) && (v < cur.vb_hi)) ^ cur.pal;  // PAL range is inverted
    endfunction

    function automatic logic probe(input int sel);
        case (sel)
            0:       return hsync;
            1:       return vsync;
            default: return active;
        endcase
    endfunction

    function automatic row_t make_row(input chip_t c, input logic hp, input logic vp,
                                      input logic cs, input hcount_t mw, input vcount_t mxh,
                                      input hcount_t xo, input int hs_s, input int hs_e,
                                      input int ha_e, input int ha_s, input int vs_s,
                                      input int vs_e, input int va_e, input int va_s);
        row_t r;
        r.chip     = c;
        r.hpol     = hp;
        r.vpol     = vp;
        r.csync    = cs;
        r.pal      = c[0];
        r.max_w    = mw;
        r.max_h    = mxh;
        r.xoff     = xo;
        r.vb_lo    = vcount_t'(2 * va_e);
        r.vb_hi    = vcount_t'(2 * va_s);
        r.line_len = mw + 1'b1;
        r.hs_w     = hcount_t'(2 * (hs_e - hs_s) + 1);   // both ends inclusive
        r.act_w    = hcount_t'(int'(mw) - 2 * (ha_s - ha_e));
        r.vs_lines = vcount_t'(2 * (vs_e - vs_s));
        r.vs_rem   = hcount_t'(2 * (hs_e - hs_s));
        return r;
    endfunction

    // ----------------------------------------------------------------------
    // reference raster model, h wraps after max_w and v after max_h
    always @(posedge clk_dvi) begin
        if (rst) begin
            mh  <= '0;
            mv  <= '0;
            mhb <= 1'b0;
        end else if (mh == cur.max_w) begin
            mh  <= '0;
            mv  <= (mv == cur.max_h) ? '0 : mv + 1'b1;
            mhb <= in_vblank(mv) ? ~mhb : 1'b0;
        end else begin
            mh <= mh + 1'b1;
        end
        mh_d1 <= mh;
        mh_d2 <= mh_d1;  // colour out lags its h by two
    end

    always @(negedge clk_dvi) begin
        if (!rst) begin
            check_bit("half_bright", mhb, half_bright);
            if (cur.csync) check_bit("vsync under csync", 1'b0, vsync);
            if (chk_col) begin
                check_color("pixel colour",
                            ref_line[(int'(mh_d2) + int'(cur.xoff)) / 2], pixel_color_out);
            end
        end
    end

    // waits for a sample at lvl whose previous sample was not
    task automatic wait_edge(input int sel, input logic lvl, input string what);
        int   n;
        logic prev;
        logic seen;
        prev = probe(sel);
        seen = 1'b0;
        n    = 0;
        while (!seen && !hung) begin
            @(negedge clk_dvi);
            seen = (prev != lvl) && (probe(sel) == lvl);
            prev = probe(sel);
            n++;
            if (!seen && n >= TMO) timed_out(what);
        end
    endtask

    // current sample is at lvl, counts until the first sample that is not
    task automatic count_run(input int sel, input logic lvl, output int n);
        logic stay;
        n    = 1;
        stay = 1'b1;
        while (stay && !hung) begin
            @(negedge clk_dvi);
            stay = (probe(sel) == lvl);
            if (stay) n++;
            if (stay && n >= TMO) timed_out("a pulse to end");
        end
    endtask

    task automatic write_pixel(input int x, input color_t c);
        @(posedge clk_dvi);
        #1;
        pixel_we    = 1'b1;
        raster_x    = rx_t'(x);
        raster_y    = ry_t'(7);  // any line but 0, no frame start
        pixel_color = c;
    endtask

    task automatic run_row(input int r);
        int     i;
        int     n;
        int     g;
        int     k;
        color_t c;
        string  tag;
        tag = $sformatf("row %0d", r);
        @(posedge clk_dvi);
        #1;
        cur          = rows[r];
        rst          = 1'b1;
        chip         = cur.chip;
        hpolarity    = cur.hpol;
        vpolarity    = cur.vpol;
        enable_csync = cur.csync;
        repeat (10) @(posedge clk_dvi);
        #1;
        rst = 1'b0;

        // fill one native line, then a line start swaps it to the read side
        for (i = 0; i < LINE_PIX; i++) begin
            next_color(c);
            ref_line[i] = c;
            write_pixel(i, c);
        end
        next_color(c);
        write_pixel(0, c);  // lands in the other buffer
        @(posedge clk_dvi);
        #1;
        pixel_we = 1'b0;
        wait_edge(0, cur.hpol, "hsync");
        wait_edge(0, cur.hpol, "hsync");
        chk_col = 1'b1;     // one whole output line
        wait_edge(0, cur.hpol, "hsync");
        chk_col = 1'b0;

        // sitting on a leading edge here
        count_run(0, cur.hpol, n);
        check_h({tag, " hsync width"}, cur.hs_w, hcount_t'(n));
        count_run(0, ~cur.hpol, g);
        check_h({tag, " line length"}, cur.line_len, hcount_t'(n + g));

        wait_edge(2, 1'b1, "active");  // PAL first reaches a visible line at 40
        count_run(2, 1'b1, n);
        check_h({tag, " active width"}, cur.act_w, hcount_t'(n));

        if (!cur.csync) begin
            wait_edge(1, cur.vpol, "vsync");
            count_run(1, cur.vpol, n);
        end else begin
            // long csync pulse, one longer than vsync since hsync still holds at hs_end
            n = 0;
            k = 0;
            while (n <= int'(cur.line_len) && !hung) begin
                wait_edge(0, cur.hpol, "hsync");
                count_run(0, cur.hpol, n);
                k++;
                if (k > int'(cur.max_h) + 2) timed_out("the csync vsync pulse");
            end
            n = n - 1;
        end
        check_v({tag, " vsync lines"}, cur.vs_lines, vcount_t'(n / int'(cur.line_len)));
        check_h({tag, " vsync remainder"}, cur.vs_rem, hcount_t'(n % int'(cur.line_len)));
    endtask

    // ----------------------------------------------------------------------
    initial begin
        rst          = 1'b1;
        chip         = CHIP_6569R3;
        hpolarity    = 1'b1;
        vpolarity    = 1'b1;
        enable_csync = 1'b0;
        pixel_we     = 1'b0;
        raster_x     = '0;
        raster_y     = '0;
        pixel_color  = '0;
        errors       = 0;
        timeouts     = 0;
        hung         = 1'b0;
        chk_col      = 1'b0;
        lfsr         = 32'h423b;

        // chip, hpol, vpol, csync, frame size, then native h and v windows
        rows[0] = make_row(CHIP_6569R3, 1'b1, 1'b1, 1'b0, PAL_MAX_W, PAL_MAX_H, PAL_X_OFFSET,
                           PAL_HS_STA, PAL_HS_END, PAL_HA_END, PAL_HA_STA,
                           PAL_VS_STA, PAL_VS_END, PAL_VA_END, PAL_VA_STA);
        rows[1] = make_row(CHIP_6567R8, 1'b0, 1'b0, 1'b0,
                           NTSC_R8_MAX_W, NTSC_R8_MAX_H, NTSC_R8_X_OFFSET,
                           NTSC_R8_HS_STA, NTSC_R8_HS_END, NTSC_R8_HA_END, NTSC_R8_HA_STA,
                           NTSC_R8_VS_STA, NTSC_R8_VS_END, NTSC_R8_VA_END, NTSC_R8_VA_STA);
        rows[2] = make_row(CHIP_6567R56A, 1'b1, 1'b0, 1'b1,
                           NTSC_R56A_MAX_W, NTSC_R56A_MAX_H, NTSC_R56A_X_OFFSET,
                           NTSC_R56A_HS_STA, NTSC_R56A_HS_END,
                           NTSC_R56A_HA_END, NTSC_R56A_HA_STA,
                           NTSC_R56A_VS_STA, NTSC_R56A_VS_END,
                           NTSC_R56A_VA_END, NTSC_R56A_VA_STA);
        rows[3] = make_row(CHIP_6569R1, 1'b0, 1'b1, 1'b1, PAL_MAX_W, PAL_MAX_H, PAL_X_OFFSET,
                           PAL_HS_STA, PAL_HS_END, PAL_HA_END, PAL_HA_STA,
                           PAL_VS_STA, PAL_VS_END, PAL_VA_END, PAL_VA_STA);

        for (int r = 0; r < NROWS && !hung; r++) begin
            run_row(r);
        end

        $display("value errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
dvi_sync_pkg.sv
line_buf_ram.sv
line_double_buffer.sv
raster_timing.sv
scan_counter.sv
sync_encoder.sv
dvi_sync_top.sv
tb_dvi_sync.sv

// ==== Makefile ====
# Verilator build and run of the DVI sync generator testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails unless it passes"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal -f list.f --top-module tb_dvi_sync -Mdir obj_dir
	./obj_dir/Vtb_dvi_sync | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
